//--- build.f
codec_pkg.sv
i2c_pkg.sv
codec_init_seq.sv
i2c_write_master.sv
codec_init_top.sv
tb_i2c_checker.sv
tb_codec_init.sv

//--- run_sim.sh
#!/bin/sh
# Builds the codec init testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_codec_init \
    -f build.f -o sim_codec_init
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_codec_init > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

//--- tb_codec_init.sv
`timescale 1ns/100ps

module tb_codec_init;

    localparam int MAX_RETRY = 2;

    logic        i_clk = 1'b0;
    logic        i_rst_n, i_start;
    logic        o_scl, o_sda_oe, o_busy, o_done, o_error;
    logic        scl_q, sda_q, slave_pull, slave_nack, nack_all, want_error;
    logic [31:0] rnd, draw;
    logic [7:0]  nack_rate;  // NACK chance per ack slot, out of 256
    int          bit_cnt, byte_no, nack_run, exp_idx;
    int          n_data, n_proto, n_status, n_timeout;

    // Open drain with pull-up, an unknown driver counts as released
    wire i_sda = !(o_sda_oe === 1'b1 || slave_pull);

    always #2 i_clk = ~i_clk;

    codec_init_top #(.CLK_DIV(4), .MAX_RETRY(MAX_RETRY)) i_dut (.*);

    tb_i2c_checker #(.MAX_RETRY(MAX_RETRY)) u_chk (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start),
        .i_scl(o_scl), .i_sda(i_sda), .i_sda_oe(o_sda_oe),
        .i_busy(o_busy), .i_done(o_done), .i_error(o_error),
        .i_slave_nack(slave_nack), .i_want_error(want_error), .o_exp_idx(exp_idx),
        .o_n_data(n_data), .o_n_proto(n_proto), .o_n_status(n_status)
    );

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Slave, acks every byte unless a NACK is drawn
    always @(posedge i_clk) begin
        scl_q <= o_scl;
        sda_q <= i_sda;
        if (!i_rst_n) begin
            slave_pull <= 1'b0;
            slave_nack <= 1'b0;
            nack_run   <= 0;
            rnd        <= 32'h2137_6429;
        end else if (o_scl && scl_q && sda_q && !i_sda) begin
            bit_cnt <= 0;  // Start
            byte_no <= 0;
        end else if (o_scl && !scl_q) begin
            bit_cnt <= bit_cnt + 1;
        end else if (!o_scl && scl_q && bit_cnt == 8) begin
            draw = next_rand(rnd);
            rnd <= draw;
            // Never more NACKs in a row than the sequencer retries
            if (nack_all || (draw[7:0] < nack_rate && nack_run < MAX_RETRY)) begin
                slave_nack <= 1'b1;
                nack_run   <= nack_run + 1;
            end else begin
                slave_pull <= 1'b1;
                if (byte_no == 2) nack_run <= 0;
            end
        end else if (!o_scl && scl_q && bit_cnt == 9) begin
            slave_pull <= 1'b0;  // Ack slot over
            slave_nack <= 1'b0;
            bit_cnt    <= 0;
            byte_no    <= byte_no + 1;
        end
    end

    // One init run, fail_idx >= 0 makes the slave refuse that entry on every try
    task automatic run_sequence(input logic [7:0] rate, input int fail_idx);
        int t;
        t = 0;
        nack_rate  <= rate;
        want_error <= (fail_idx >= 0);
        i_start    <= 1'b1;
        @(posedge i_clk);
        i_start <= 1'b0;
        @(posedge i_clk);
        while (!o_done && t < 8000) begin
            @(posedge i_clk);
            t++;
            if (fail_idx >= 0 && exp_idx == fail_idx) nack_all <= 1'b1;
        end
        if (!o_done) begin
            $display("Timeout, o_done did not rise within 8000 cycles at %0t", $time);
            n_timeout++;
        end
        repeat (400) @(posedge i_clk);  // Window where a stray frame would show
        nack_all <= 1'b0;
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_start    = 1'b0;
        slave_pull = 1'b0;
        slave_nack = 1'b0;
        nack_all   = 1'b0;
        nack_rate  = 8'd0;
        want_error = 1'b0;
        n_timeout  = 0;
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (20) @(posedge i_clk);
        run_sequence(8'd0, -1);   // Clean bus
        run_sequence(8'd40, -1);  // Random NACKs
        run_sequence(8'd0, 3);    // Entry 3 gives up
        run_sequence(8'd0, -1);   // Restart clears the error
        $display("Errors: data %0d, protocol %0d, status %0d, timeout %0d",
                 n_data, n_proto, n_status, n_timeout);
        if (n_data + n_proto + n_status + n_timeout == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tb_i2c_checker.sv
`timescale 1ns/100ps

module tb_i2c_checker #(
    parameter int MAX_RETRY = 2
) (
    input  logic i_clk, i_rst_n, i_start,
    input  logic i_scl, i_sda, i_sda_oe,  // Bus as seen on the pins
    input  logic i_busy, i_done, i_error,
    input  logic i_slave_nack,             // Slave refuses the current ack slot
    input  logic i_want_error,             // Scenario is meant to end in a give-up
    output int   o_exp_idx,
    output int   o_n_data, o_n_proto, o_n_status
);

    logic        scl_q, sda_q, done_q, rst_q;
    logic        in_frame, nacked, exp_done, exp_error;
    logic [7:0]  shift;
    logic [26:0] image;
    int          bit_cnt, n_bytes, retry;

    // Bus image of one table entry, three bytes each followed by a zero ack bit
    function automatic logic [26:0] ref_frame(input int idx);
        codec_pkg::codec_reg_write_t w;
        w = codec_pkg::CODEC_INIT_TABLE[idx];
        return {codec_pkg::CODEC_DEV_ADDR, 1'b0, 1'b0, w.reg_addr, w.reg_data[8], 1'b0,
                w.reg_data[7:0], 1'b0};
    endfunction

    always @(posedge i_clk) begin
        scl_q  <= i_scl;
        sda_q  <= i_sda;
        done_q <= i_done;
        rst_q  <= i_rst_n;
        if (!i_rst_n) begin
            in_frame  <= 1'b0;
            o_exp_idx <= 0;
            retry     <= 0;
            exp_done  <= 1'b0;
            exp_error <= 1'b0;
            o_n_data   = 0;
            o_n_proto  = 0;
            o_n_status = 0;
        end else begin
            if (!rst_q && {i_scl, i_sda_oe, i_busy, i_done, i_error} != 5'b10000) begin
                $display("[ERROR] {o_scl,o_sda_oe,o_busy,o_done,o_error}: got %h, expected %h",
                         {i_scl, i_sda_oe, i_busy, i_done, i_error}, 5'b10000);
                o_n_status++;
            end
            if (i_start && !i_busy) begin  // Sequencer restarts from entry 0
                o_exp_idx <= 0;
                retry     <= 0;
                exp_done  <= 1'b0;
                exp_error <= 1'b0;
            end
            if (i_scl != scl_q && i_sda != sda_q) begin
                $display("SDA and SCL changed in the same cycle at %0t", $time);
                o_n_proto++;
            end

            if (i_scl && scl_q && sda_q && !i_sda) begin
                // Start
                if (in_frame || exp_done) begin
                    $display("Unexpected start condition at %0t", $time);
                    o_n_proto++;
                end
                if (!i_busy) begin
                    $display("[ERROR] o_busy during a frame: got %h, expected %h",
                             i_busy, 1'b1);
                    o_n_status++;
                end
                in_frame <= 1'b1;
                bit_cnt  <= 0;
                n_bytes  <= 0;
                nacked   <= 1'b0;
            end else if (i_scl && scl_q && !sda_q && i_sda && in_frame) begin
                // Stop, one SCL rise after the last ack slot
                in_frame <= 1'b0;
                if (bit_cnt != 1 || (!nacked && n_bytes != 3)) begin
                    $display("Stop condition out of place at %0t", $time);
                    o_n_proto++;
                end
                if (!exp_done && !nacked) begin
                    retry     <= 0;
                    o_exp_idx <= o_exp_idx + 1;
                    exp_done  <= (o_exp_idx == codec_pkg::CODEC_N_REGS - 1);
                end else if (!exp_done && retry < MAX_RETRY) begin
                    retry <= retry + 1;  // Same entry comes again
                end else if (!exp_done) begin
                    exp_done  <= 1'b1;
                    exp_error <= 1'b1;
                end
            end else if (i_scl && !scl_q && in_frame) begin
                if (bit_cnt < 8) begin
                    shift   <= {shift[6:0], i_sda};
                    bit_cnt <= bit_cnt + 1;
                end else begin
                    bit_cnt <= 0;   // Ack slot closes the byte
                    n_bytes <= n_bytes + 1;
                    nacked  <= nacked | i_sda;
                    if (nacked || n_bytes > 2) begin
                        $display("Frame went on after a NACK or past three bytes at %0t", $time);
                        o_n_proto++;
                    end else if (!exp_done) begin
                        image = ref_frame(o_exp_idx);
                        if (shift != image[26 - 9 * n_bytes -: 8]) begin
                            $display("[ERROR] SDA byte %0d of entry %0d: got %h, expected %h",
                                     n_bytes, o_exp_idx, shift, image[26 - 9 * n_bytes -: 8]);
                            o_n_data++;
                        end
                    end
                    if (i_sda != i_slave_nack) begin
                        $display("[ERROR] SDA ack bit: got %h, expected %h", i_sda, i_slave_nack);
                        o_n_data++;
                    end
                end
            end

            if (i_done && !done_q) begin
                if ({i_done, i_error, i_busy} != {exp_done, exp_error, 1'b0}) begin
                    $display("[ERROR] {o_done,o_error,o_busy}: got %h, expected %h",
                             {i_done, i_error, i_busy}, {exp_done, exp_error, 1'b0});
                    o_n_status++;
                end
                if (exp_error != i_want_error) begin
                    $display("Sequence outcome does not match the test scenario at %0t", $time);
                    o_n_status++;
                end
            end
        end
    end

endmodule

//--- codec_init_top.sv
`timescale 1ns/100ps

module codec_init_top #(
    parameter int CLK_DIV   = 4,
    parameter int MAX_RETRY = 2
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sda,     // Resolved SDA line
    output logic o_scl,
    output logic o_sda_oe,  // High pulls SDA low
    output logic o_busy,
    output logic o_done,
    output logic o_error
);

    logic                 cmd_valid;
    logic                 cmd_ready;
    i2c_pkg::i2c_frame_t  cmd_frame;
    logic                 rsp_valid;
    i2c_pkg::i2c_result_t rsp;

    codec_init_seq #(
        .MAX_RETRY (MAX_RETRY)
    ) u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .o_cmd_valid (cmd_valid),
        .o_cmd_frame (cmd_frame),
        .i_cmd_ready (cmd_ready),
        .i_rsp_valid (rsp_valid),
        .i_rsp       (rsp),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_error     (o_error)
    );

    i2c_write_master #(
        .CLK_DIV (CLK_DIV)
    ) u_master (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_valid (cmd_valid),
        .i_cmd_frame (cmd_frame),
        .o_cmd_ready (cmd_ready),
        .o_rsp_valid (rsp_valid),
        .o_rsp       (rsp),
        .o_scl       (o_scl),
        .o_sda_oe    (o_sda_oe),
        .i_sda       (i_sda)
    );

endmodule

//--- i2c_write_master.sv
`timescale 1ns/100ps

module i2c_write_master #(
    parameter int CLK_DIV = 4
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_cmd_valid,
    input  i2c_pkg::i2c_frame_t    i_cmd_frame,
    output logic                   o_cmd_ready,
    output logic                   o_rsp_valid,
    output i2c_pkg::i2c_result_t   o_rsp,
    output logic                   o_scl,
    output logic                   o_sda_oe,
    input  logic                   i_sda
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam int MID   = CLK_DIV / 2;

    i2c_pkg::i2c_phase_e phase;
    logic [DIV_W-1:0]    div_cnt;
    logic                half_end;
    logic                mid;
    logic [2:0]          bit_cnt;
    logic [1:0]          byte_cnt;
    logic                nack;
    logic [23:0]         shift;

    assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign mid      = (div_cnt == DIV_W'(MID));

    assign o_cmd_ready = (phase == i2c_pkg::PH_IDLE);
    assign o_rsp       = '{nack: nack, byte_idx: byte_cnt};

    // Address byte with write bit, then the two data bytes, MSB first
    always_ff @(posedge i_clk) begin
        if (phase == i2c_pkg::PH_IDLE && i_cmd_valid) begin
            shift <= {i_cmd_frame.dev_addr, 1'b0, i_cmd_frame.byte1, i_cmd_frame.byte2};
        end else if (phase == i2c_pkg::PH_BIT_HI && half_end) begin
            shift <= {shift[22:0], 1'b0};
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            phase       <= i2c_pkg::PH_IDLE;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            nack        <= 1'b0;
            o_scl       <= 1'b1;
            o_sda_oe    <= 1'b0;
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;

            // Half period timer, idle only while the bus is free
            if (phase == i2c_pkg::PH_IDLE || half_end) div_cnt <= '0;
            else div_cnt <= div_cnt + 1'b1;

            case (phase)
                i2c_pkg::PH_IDLE: begin
                    if (i_cmd_valid) begin
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                        nack     <= 1'b0;
                        o_sda_oe <= 1'b1;  // Start, SDA falls with SCL high
                        phase    <= i2c_pkg::PH_START;
                    end
                end
                i2c_pkg::PH_START: begin
                    if (half_end) begin
                        o_scl <= 1'b0;
                        phase <= i2c_pkg::PH_BIT_LO;
                    end
                end
                i2c_pkg::PH_BIT_LO: begin
                    if (mid) o_sda_oe <= ~shift[23];  // Data changes mid low half
                    if (half_end) begin
                        o_scl <= 1'b1;
                        phase <= i2c_pkg::PH_BIT_HI;
                    end
                end
                i2c_pkg::PH_BIT_HI: begin
                    if (half_end) begin
                        o_scl   <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;  // Wraps to 0 after each byte
                        if (bit_cnt == 3'd7) phase <= i2c_pkg::PH_ACK_LO;
                        else phase <= i2c_pkg::PH_BIT_LO;
                    end
                end
                i2c_pkg::PH_ACK_LO: begin
                    if (mid) o_sda_oe <= 1'b0;  // Hand SDA to the slave
                    if (half_end) begin
                        o_scl <= 1'b1;
                        phase <= i2c_pkg::PH_ACK_HI;
                    end
                end
                i2c_pkg::PH_ACK_HI: begin
                    if (div_cnt == '0) nack <= i_sda;  // First cycle with SCL high
                    if (half_end) begin
                        o_scl <= 1'b0;
                        if (nack || byte_cnt == 2'd2) begin
                            phase <= i2c_pkg::PH_STOP;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            phase    <= i2c_pkg::PH_BIT_LO;
                        end
                    end
                end
                i2c_pkg::PH_STOP: begin
                    // Low half pulls SDA down, high half lets it rise
                    if (mid) o_sda_oe <= ~o_scl;
                    if (half_end) begin
                        if (!o_scl) begin
                            o_scl <= 1'b1;
                        end else begin
                            o_rsp_valid <= 1'b1;
                            phase       <= i2c_pkg::PH_IDLE;
                        end
                    end
                end
                default: phase <= i2c_pkg::PH_IDLE;
            endcase
        end
    end

    a_rsp_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_rsp_valid |=> !o_rsp_valid);

    // Only start and stop may move SDA while SCL is high
    a_sda_scl_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_scl && $past(o_scl) && phase != i2c_pkg::PH_START
         && phase != i2c_pkg::PH_STOP) |-> $stable(o_sda_oe));

endmodule

//--- codec_init_seq.sv
`timescale 1ns/100ps

module codec_init_seq #(
    parameter int MAX_RETRY = 2
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_start,
    output logic                   o_cmd_valid,
    output i2c_pkg::i2c_frame_t    o_cmd_frame,
    input  logic                   i_cmd_ready,
    input  logic                   i_rsp_valid,
    input  i2c_pkg::i2c_result_t   i_rsp,
    output logic                   o_busy,
    output logic                   o_done,
    output logic                   o_error
);

    localparam int IDX_W   = $clog2(codec_pkg::CODEC_N_REGS);
    localparam int RETRY_W = (MAX_RETRY > 0) ? $clog2(MAX_RETRY + 1) : 1;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,   // Frame offered to the master
        SEQ_WAIT,    // Frame on the bus, waiting for the result
        SEQ_DONE
    } seq_state_e;

    seq_state_e                  state;
    logic [IDX_W-1:0]            idx;
    logic [RETRY_W-1:0]          retry_cnt;
    codec_pkg::codec_reg_write_t entry;

    assign entry = codec_pkg::CODEC_INIT_TABLE[idx];

    // Register address goes out with data bit 8 in the low bit
    assign o_cmd_frame.dev_addr = codec_pkg::CODEC_DEV_ADDR;
    assign o_cmd_frame.byte1    = {entry.reg_addr, entry.reg_data[8]};
    assign o_cmd_frame.byte2    = entry.reg_data[7:0];

    assign o_cmd_valid = (state == SEQ_ISSUE);
    assign o_busy      = (state == SEQ_ISSUE) || (state == SEQ_WAIT);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= SEQ_IDLE;
            idx       <= '0;
            retry_cnt <= '0;
            o_done    <= 1'b0;
            o_error   <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE, SEQ_DONE: begin
                    if (i_start) begin
                        idx       <= '0;
                        retry_cnt <= '0;
                        o_done    <= 1'b0;
                        o_error   <= 1'b0;
                        state     <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    if (i_cmd_ready) state <= SEQ_WAIT;  // Handshake done
                end
                SEQ_WAIT: begin
                    if (i_rsp_valid) begin
                        if (!i_rsp.nack) begin
                            retry_cnt <= '0;
                            if (idx == IDX_W'(codec_pkg::CODEC_N_REGS - 1)) begin
                                o_done <= 1'b1;
                                state  <= SEQ_DONE;
                            end else begin
                                idx   <= idx + 1'b1;
                                state <= SEQ_ISSUE;
                            end
                        end else if (retry_cnt < RETRY_W'(MAX_RETRY)) begin
                            retry_cnt <= retry_cnt + 1'b1;  // Same entry again
                            state     <= SEQ_ISSUE;
                        end else begin
                            // Out of tries for this entry
                            o_done  <= 1'b1;
                            o_error <= 1'b1;
                            state   <= SEQ_DONE;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Offered frame may not move until the master takes it
    a_cmd_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_cmd_valid && !i_cmd_ready |=> o_cmd_valid && $stable(o_cmd_frame));

endmodule

//--- i2c_pkg.sv
package i2c_pkg;

    // One write frame, address byte is dev_addr plus a zero write bit
    typedef struct packed {
        logic [6:0] dev_addr;
        logic [7:0] byte1;    // Register address and data bit 8
        logic [7:0] byte2;    // Data bits 7 to 0
    } i2c_frame_t;

    // Outcome of one frame
    typedef struct packed {
        logic       nack;
        logic [1:0] byte_idx;  // Byte that got the NACK, 0 is the address byte
    } i2c_result_t;

    // Master bus phases
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_BIT_LO,
        PH_BIT_HI,
        PH_ACK_LO,
        PH_ACK_HI,
        PH_STOP
    } i2c_phase_e;

endpackage

//--- codec_pkg.sv
package codec_pkg;

    // 7-bit I2C address of the codec, 8'h34 on the wire with the write bit
    localparam logic [6:0] CODEC_DEV_ADDR = 7'h1A;

    localparam int CODEC_N_REGS = 7;

    // One codec register write, 7-bit address and 9-bit data
    typedef struct packed {
        logic [6:0] reg_addr;
        logic [8:0] reg_data;
    } codec_reg_write_t;

    // Power-up sequence, sent in index order
    localparam codec_reg_write_t CODEC_INIT_TABLE [CODEC_N_REGS] = '{
        '{reg_addr: 7'h0F, reg_data: 9'h000},  // Reset
        '{reg_addr: 7'h04, reg_data: 9'h015},  // Analogue audio path
        '{reg_addr: 7'h05, reg_data: 9'h000},  // Digital audio path
        '{reg_addr: 7'h06, reg_data: 9'h000},  // Power down control
        '{reg_addr: 7'h07, reg_data: 9'h042},  // Interface format
        '{reg_addr: 7'h08, reg_data: 9'h019},  // Sampling control
        '{reg_addr: 7'h09, reg_data: 9'h001}   // Active
    };

endpackage
